//--- neuron_core.f
+incdir+common
common/neuron_pkg.sv
spike_interface/flit_fifo.sv
spike_interface/spike_interface.sv
logic/synapse_config.sv
logic/neuron_update.sv
logic/neuron_core.sv
test/neuron_core_asserts.sv
test/neuron_core_tb.sv

//--- Makefile
# Verilator build and run for the neuron core tile testbench

VERILATOR  ?= verilator
TOP        ?= neuron_core_tb
FILELIST   ?= neuron_core.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- test/neuron_core_tb.sv
`timescale 1ns/1ps
`include "neuron_settings.svh"

module neuron_core_tb;

    localparam int NUM_WEIGHTS   = `NC_NUM_NEURONS * `NC_NUM_AXONS;
    localparam int AXON_LSB      = `NC_X_ADDR_W + `NC_Y_ADDR_W;
    localparam int POT_MAX       = (1 << (`NC_POTENTIAL_W - 1)) - 1;
    localparam int POT_MIN       = -(1 << (`NC_POTENTIAL_W - 1));
    // one cycle per weight pair, then the capture and the fire cycle
    localparam int STEP_LATENCY  = NUM_WEIGHTS + 2;
    localparam int RANDOM_STEPS  = 30;
    localparam int SAT_STEPS     = 72;
    localparam int PROBE_STEPS   = 4;
    localparam int MAX_PACKETS   = 8;
    localparam int IDLE_CYCLES   = 12;
    localparam int APB_TRANSFERS = 120;
    // a full burst at two router cycles per flit plus the update bounds one step
    localparam int STEP_CYCLES   = MAX_PACKETS * `NC_FLITS_PER_PACKET * 2 + 64;
    localparam int TIMEOUT_CYCLES =
        2 * ((RANDOM_STEPS + SAT_STEPS + PROBE_STEPS) * STEP_CYCLES + 3 * APB_TRANSFERS);

    logic                      neuron_clk;
    logic                      router_clk;
    logic                      rst_n;
    logic                      write_en;
    neuron_pkg::flit_t         data_in;
    logic                      neuron_full;
    logic                      start;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`NC_APB_ADDR_W-1:0] paddr;
    logic [`NC_APB_DATA_W-1:0] pwdata;
    logic [`NC_APB_DATA_W-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    neuron_pkg::fire_vec_t     fire;
    logic                      busy;
    logic                      step_done;

    // reference model state
    int          model_weight [NUM_WEIGHTS];
    int          model_threshold;
    int          model_potential [`NC_NUM_NEURONS];
    logic [31:0] rng_state;
    int          errors;
    int          steps_run;
    int          apb_count;
    int          cycle_count;
    int          num_packets;

    neuron_core i_neuron_core
    (
        .neuron_clk  (neuron_clk),
        .router_clk  (router_clk),
        .rst_n       (rst_n),
        .write_en    (write_en),
        .data_in     (data_in),
        .neuron_full (neuron_full),
        .start       (start),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .fire        (fire),
        .busy        (busy),
        .step_done   (step_done)
    );

    always #2 neuron_clk = ~neuron_clk;
    always #1.5 router_clk = ~router_clk;

    // the run is stopped if it takes longer than the tests can ever need
    always @(posedge neuron_clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not end within %0d neuron cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // 32 bit xorshift generator
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic report_fail(input string msg);
        errors++;
        $display("[FAIL] %0.3f ns: %s", $realtime, msg);
    endtask

    // integrate every spiking axon into each neuron, then fire and reset
    function automatic neuron_pkg::fire_vec_t model_step(input neuron_pkg::spike_vec_t spk);
        neuron_pkg::fire_vec_t expect_fire;
        int                    sum;
        expect_fire = '0;
        for (int n = 0; n < `NC_NUM_NEURONS; n++)
        begin
            for (int a = 0; a < `NC_NUM_AXONS; a++)
            begin
                if (spk[a])
                begin
                    sum = model_potential[n] + model_weight[n * `NC_NUM_AXONS + a];
                    // the potential clamps at the signed limits instead of wrapping
                    if (sum > POT_MAX)
                        sum = POT_MAX;
                    if (sum < POT_MIN)
                        sum = POT_MIN;
                    model_potential[n] = sum;
                end
            end
            if (model_potential[n] >= model_threshold)
            begin
                expect_fire[n]     = 1'b1;
                model_potential[n] = 0;
            end
        end
        return expect_fire;
    endfunction

    // setup phase, access phase, then one idle cycle
    task automatic apb_transfer(input logic wr, input logic [`NC_APB_ADDR_W-1:0] addr,
                                input logic [`NC_APB_DATA_W-1:0] wdata,
                                output logic [`NC_APB_DATA_W-1:0] rdata, output logic err);
        @(negedge neuron_clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge neuron_clk);
        penable = 1'b1;
        @(posedge neuron_clk);
        rdata = prdata;
        err   = pslverr;
        @(negedge neuron_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        apb_count++;
    endtask

    // weight of neuron n, axon a sits at byte address (n*4+a)*4
    task automatic program_weights(input int base, input int span);
        logic [`NC_APB_DATA_W-1:0] rdata;
        logic                      err;
        int                        w;
        for (int i = 0; i < NUM_WEIGHTS; i++)
        begin
            w = base + int'(next_random() % 32'(span));
            apb_transfer(1'b1, `NC_APB_ADDR_W'(i * 4), `NC_APB_DATA_W'(w), rdata, err);
            if (err !== 1'b0)
                report_fail($sformatf("pslverr on write of weight %0d", i));
            model_weight[i] = w;
        end
    endtask

    task automatic program_threshold(input int value);
        logic [`NC_APB_DATA_W-1:0] rdata;
        logic                      err;
        apb_transfer(1'b1, `NC_APB_ADDR_W'(`NC_THRESHOLD_ADDR), `NC_APB_DATA_W'(value),
                     rdata, err);
        if (err !== 1'b0)
            report_fail("pslverr on threshold write");
        model_threshold = value;
    endtask

    // each register returns the whole word that was written to it
    task automatic check_readback();
        logic [`NC_APB_DATA_W-1:0] rdata;
        logic                      err;
        for (int i = 0; i < NUM_WEIGHTS; i++)
        begin
            apb_transfer(1'b0, `NC_APB_ADDR_W'(i * 4), '0, rdata, err);
            if (err !== 1'b0 || rdata !== `NC_APB_DATA_W'(model_weight[i]))
                report_fail($sformatf("weight %0d read 0x%0h err %b", i, rdata, err));
        end
        apb_transfer(1'b0, `NC_APB_ADDR_W'(`NC_THRESHOLD_ADDR), '0, rdata, err);
        if (err !== 1'b0 || rdata !== `NC_APB_DATA_W'(model_threshold))
            report_fail($sformatf("threshold read 0x%0h err %b", rdata, err));
    endtask

    // addresses above the threshold register are unmapped
    task automatic check_bad_access();
        logic [`NC_APB_ADDR_W-1:0] addr;
        logic [`NC_APB_DATA_W-1:0] rdata;
        logic                      err;
        repeat (4)
        begin
            addr = `NC_APB_ADDR_W'(`NC_THRESHOLD_ADDR + 1 + (next_random() % 32'd191));
            apb_transfer(1'b1, addr, next_random(), rdata, err);
            if (err !== 1'b1)
                report_fail($sformatf("no pslverr on write to 0x%0h", addr));
            apb_transfer(1'b0, addr, '0, rdata, err);
            if (err !== 1'b1 || rdata !== '0)
                report_fail($sformatf("read of 0x%0h gave 0x%0h err %b", addr, rdata, err));
        end
    endtask

    // flit 0 carries the lowest nibble, and a flit waits while neuron_full is high
    task automatic send_packet(input neuron_pkg::packet_t pkt);
        for (int k = 0; k < `NC_FLITS_PER_PACKET; k++)
        begin
            @(negedge router_clk);
            while (neuron_full)
            begin
                write_en = 1'b0;
                @(negedge router_clk);
            end
            write_en = 1'b1;
            data_in  = pkt[k * `NC_FLIT_W +: `NC_FLIT_W];
        end
        @(negedge router_clk);
        write_en = 1'b0;
    endtask

    task automatic run_step(input int count, input bit all_axons, input bit start_while_busy);
        neuron_pkg::packet_t    pkt;
        neuron_pkg::spike_vec_t sent;
        neuron_pkg::fire_vec_t  expect_fire;
        int                     latency;
        sent = '0;
        for (int i = 0; i < count; i++)
        begin
            pkt = next_random();
            // sweep the axon ids in order when every axon has to spike
            if (all_axons)
                pkt[AXON_LSB +: `NC_AXON_ID_W] = neuron_pkg::axon_id_t'(i);
            sent[pkt[AXON_LSB +: `NC_AXON_ID_W]] = 1'b1;
            send_packet(pkt);
        end
        // the interface stays quiet so that every packet has landed before start
        repeat (IDLE_CYCLES) @(negedge neuron_clk);
        expect_fire = model_step(sent);
        start   = 1'b1;
        latency = 0;
        do
        begin
            @(negedge neuron_clk);
            latency++;
            // a second start in the middle of the step only clears the spike register
            start = start_while_busy && (latency == 5);
        end
        while (step_done !== 1'b1);
        if (latency != STEP_LATENCY)
            report_fail($sformatf("step_done after %0d cycles, expected %0d",
                                  latency, STEP_LATENCY));
        if (fire !== expect_fire)
            report_fail($sformatf("step %0d fire %b, expected %b",
                                  steps_run, fire, expect_fire));
        if (busy !== 1'b0)
            report_fail("busy still high with step_done");
        @(negedge neuron_clk);
        if (step_done !== 1'b0)
            report_fail("step_done high for more than one cycle");
        steps_run++;
    endtask

    initial
    begin
        neuron_clk  = 1'b0;
        router_clk  = 1'b0;
        rst_n       = 1'b0;
        write_en    = 1'b0;
        data_in     = '0;
        start       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        rng_state   = 32'd48;
        errors      = 0;
        steps_run   = 0;
        apb_count   = 0;
        cycle_count = 0;
        model_threshold = 0;
        for (int n = 0; n < `NC_NUM_NEURONS; n++)
            model_potential[n] = 0;
        for (int i = 0; i < NUM_WEIGHTS; i++)
            model_weight[i] = 0;

        repeat (3) @(negedge neuron_clk);
        rst_n = 1'b1;
        @(negedge neuron_clk);
        if (neuron_full !== 1'b0 || busy !== 1'b0 || step_done !== 1'b0 ||
            fire !== '0 || pslverr !== 1'b0)
            report_fail("outputs not cleared by reset");

        // weights and threshold come out of reset as zero
        check_readback();

        // register map, readback and unmapped accesses
        program_weights(-128, 256);
        program_threshold(1 + int'(next_random() % 32'd400));
        check_readback();
        check_bad_access();
        check_readback();

        // random traffic, with empty steps and starts while busy mixed in
        for (int s = 0; s < RANDOM_STEPS; s++)
        begin
            num_packets = (s % 6 == 5) ? 0 : int'(next_random() % 32'(MAX_PACKETS + 1));
            run_step(num_packets, 1'b0, s % 4 == 3);
        end

        // strong negative weights drive every potential into the lower limit
        program_weights(-128, 8);
        program_threshold(1000);
        for (int s = 0; s < SAT_STEPS; s++)
            run_step(4, 1'b1, 1'b0);

        // a clamped potential stays below this threshold, a wrapped one would not
        program_weights(127, 1);
        program_threshold(-32000);
        run_step(0, 1'b0, 1'b0);
        for (int s = 1; s < PROBE_STEPS; s++)
            run_step(4, 1'b1, 1'b0);

        $display("summary: %0d errors, %0d steps, %0d APB transfers",
                 errors, steps_run, apb_count);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- test/neuron_core_asserts.sv
`timescale 1ns/1ps
`include "neuron_settings.svh"

module neuron_core_asserts
(
    input logic neuron_clk,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic step_done,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr
);

    // sixteen weight pairs plus the capture cycle and the fire cycle
    localparam int STEP_LATENCY = `NC_NUM_NEURONS * `NC_NUM_AXONS + 2;

    // step_done is a single cycle pulse
    step_done_pulse: assert property (@(posedge neuron_clk) disable iff (!rst_n)
        step_done |=> !step_done)
        else $error("step_done stayed high for more than one cycle");

    // the engine goes idle on the same edge that reports the step
    busy_with_done: assert property (@(posedge neuron_clk) disable iff (!rst_n)
        $fell(busy) == $rose(step_done))
        else $error("busy and step_done edges are not aligned");

    // an accepted start always yields a result after the fixed walk
    done_latency: assert property (@(posedge neuron_clk) disable iff (!rst_n)
        (start && !busy) |-> ##STEP_LATENCY step_done)
        else $error("step_done missing after an accepted start");

    // the APB slave has no wait states
    pready_high: assert property (@(posedge neuron_clk) disable iff (!rst_n)
        pready)
        else $error("pready dropped");

    pslverr_access: assert property (@(posedge neuron_clk) disable iff (!rst_n)
        pslverr |-> (psel && penable))
        else $error("pslverr outside the APB access phase");

endmodule

bind neuron_core neuron_core_asserts i_neuron_core_asserts
(
    .neuron_clk (neuron_clk),
    .rst_n      (rst_n),
    .start      (start),
    .busy       (busy),
    .step_done  (step_done),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready),
    .pslverr    (pslverr)
);

//--- logic/neuron_core.sv
`timescale 1ns/1ps
`include "neuron_settings.svh"

module neuron_core
(
    input  logic                      neuron_clk,
    input  logic                      router_clk,
    input  logic                      rst_n,
    input  logic                      write_en,
    input  neuron_pkg::flit_t         data_in,
    output logic                      neuron_full,
    input  logic                      start,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`NC_APB_ADDR_W-1:0] paddr,
    input  logic [`NC_APB_DATA_W-1:0] pwdata,
    output logic [`NC_APB_DATA_W-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    output neuron_pkg::fire_vec_t     fire,
    output logic                      busy,
    output logic                      step_done
);

    neuron_pkg::spike_vec_t spikes;
    neuron_pkg::neuron_id_t weight_neuron;
    neuron_pkg::axon_id_t   weight_axon;
    neuron_pkg::weight_t    weight;
    neuron_pkg::potential_t threshold;

    // router flits in, spike vector out
    spike_interface i_spike_interface
    (
        .router_clk  (router_clk),
        .neuron_clk  (neuron_clk),
        .rst_n       (rst_n),
        .write_en    (write_en),
        .data_in     (data_in),
        .start       (start),
        .spikes      (spikes),
        .neuron_full (neuron_full)
    );

    // host side weights and threshold
    synapse_config i_synapse_config
    (
        .neuron_clk    (neuron_clk),
        .rst_n         (rst_n),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .weight_neuron (weight_neuron),
        .weight_axon   (weight_axon),
        .weight        (weight),
        .threshold     (threshold)
    );

    neuron_update i_neuron_update
    (
        .neuron_clk    (neuron_clk),
        .rst_n         (rst_n),
        .start         (start),
        .spikes        (spikes),
        .weight        (weight),
        .threshold     (threshold),
        .weight_neuron (weight_neuron),
        .weight_axon   (weight_axon),
        .fire          (fire),
        .busy          (busy),
        .step_done     (step_done)
    );

endmodule

//--- logic/neuron_update.sv
`timescale 1ns/1ps
`include "neuron_settings.svh"

module neuron_update
(
    input  logic                   neuron_clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  neuron_pkg::spike_vec_t spikes,
    input  neuron_pkg::weight_t    weight,
    input  neuron_pkg::potential_t threshold,
    output neuron_pkg::neuron_id_t weight_neuron,
    output neuron_pkg::axon_id_t   weight_axon,
    output neuron_pkg::fire_vec_t  fire,
    output logic                   busy,
    output logic                   step_done
);

    neuron_pkg::update_state_e state;
    neuron_pkg::neuron_id_t    neuron_idx;
    neuron_pkg::axon_id_t      axon_idx;
    neuron_pkg::spike_vec_t    spike_snap;
    neuron_pkg::potential_t    potential [`NC_NUM_NEURONS];
    logic                      last_pair;

    // add one weight to a potential and clamp at the signed limits
    function automatic neuron_pkg::potential_t sat_add
    (
        input neuron_pkg::potential_t pot,
        input neuron_pkg::weight_t    w
    );
        logic signed [`NC_POTENTIAL_W:0] sum;
        sum = pot + w;
        // the two top bits differ only when the true sum left the range
        if (sum[`NC_POTENTIAL_W] != sum[`NC_POTENTIAL_W-1])
        begin
            return sum[`NC_POTENTIAL_W] ? {1'b1, {(`NC_POTENTIAL_W-1){1'b0}}}
                                        : {1'b0, {(`NC_POTENTIAL_W-1){1'b1}}};
        end
        return sum[`NC_POTENTIAL_W-1:0];
    endfunction

    // the walk order is axon first, then neuron, one pair per cycle
    assign last_pair = (neuron_idx == neuron_pkg::neuron_id_t'(`NC_NUM_NEURONS - 1)) &&
                       (axon_idx == neuron_pkg::axon_id_t'(`NC_NUM_AXONS - 1));

    // the weight lookup answers combinationally for the current pair
    assign weight_neuron = neuron_idx;
    assign weight_axon   = axon_idx;

    always_ff @(posedge neuron_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= neuron_pkg::IDLE;
            neuron_idx <= '0;
            axon_idx   <= '0;
            spike_snap <= '0;
            fire       <= '0;
            busy       <= 1'b0;
            step_done  <= 1'b0;
            for (int n = 0; n < `NC_NUM_NEURONS; n++)
            begin
                potential[n] <= '0;
            end
        end
        else
        begin
            step_done <= 1'b0;
            case (state)
                neuron_pkg::IDLE:
                begin
                    // the spike register is sampled in the start cycle, before
                    // the interface clears it on the following edge
                    if (start)
                    begin
                        spike_snap <= spikes;
                        neuron_idx <= '0;
                        axon_idx   <= '0;
                        busy       <= 1'b1;
                        state      <= neuron_pkg::ACCUMULATE;
                    end
                end
                neuron_pkg::ACCUMULATE:
                begin
                    // silent axons still cost a cycle, which keeps the step length fixed
                    if (spike_snap[axon_idx])
                    begin
                        potential[neuron_idx] <= sat_add(potential[neuron_idx], weight);
                    end
                    {neuron_idx, axon_idx} <= {neuron_idx, axon_idx} + 1'b1;
                    if (last_pair)
                    begin
                        state <= neuron_pkg::FIRE;
                    end
                end
                neuron_pkg::FIRE:
                begin
                    // neurons below threshold keep their potential for the next step
                    for (int n = 0; n < `NC_NUM_NEURONS; n++)
                    begin
                        if (potential[n] >= threshold)
                        begin
                            fire[n]      <= 1'b1;
                            potential[n] <= '0;
                        end
                        else
                        begin
                            fire[n] <= 1'b0;
                        end
                    end
                    step_done <= 1'b1;
                    busy      <= 1'b0;
                    state     <= neuron_pkg::IDLE;
                end
                default:
                begin
                    state <= neuron_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

//--- logic/synapse_config.sv
`timescale 1ns/1ps
`include "neuron_settings.svh"

module synapse_config
(
    input  logic                       neuron_clk,
    input  logic                       rst_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`NC_APB_ADDR_W-1:0]  paddr,
    input  logic [`NC_APB_DATA_W-1:0]  pwdata,
    output logic [`NC_APB_DATA_W-1:0]  prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  neuron_pkg::neuron_id_t     weight_neuron,
    input  neuron_pkg::axon_id_t       weight_axon,
    output neuron_pkg::weight_t        weight,
    output neuron_pkg::potential_t     threshold
);

    localparam int NUM_WEIGHTS = `NC_NUM_NEURONS * `NC_NUM_AXONS;
    localparam int IDX_W       = $clog2(NUM_WEIGHTS);

    neuron_pkg::weight_t    weight_reg [NUM_WEIGHTS];
    neuron_pkg::potential_t threshold_reg;
    logic [IDX_W-1:0]       weight_index;
    logic                   access;
    logic                   weight_hit;
    logic                   threshold_hit;
    logic                   bad_addr;

    // transfers complete in the access phase and never stall
    assign access = psel && penable;
    assign pready = 1'b1;

    // weights fill the word addresses below the threshold register
    assign weight_hit    = (paddr < `NC_APB_ADDR_W'(`NC_THRESHOLD_ADDR));
    assign threshold_hit = (paddr == `NC_APB_ADDR_W'(`NC_THRESHOLD_ADDR));
    assign bad_addr      = (paddr > `NC_APB_ADDR_W'(`NC_THRESHOLD_ADDR));
    assign weight_index  = paddr[IDX_W+1:2];

    assign pslverr = access && bad_addr;

    always_ff @(posedge neuron_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_WEIGHTS; i++)
            begin
                weight_reg[i] <= '0;
            end
            threshold_reg <= '0;
        end
        else if (access && pwrite)
        begin
            // writes outside the map fall through and leave everything alone
            if (weight_hit)
            begin
                weight_reg[weight_index] <= pwdata[`NC_WEIGHT_W-1:0];
            end
            else if (threshold_hit)
            begin
                threshold_reg <= pwdata[`NC_POTENTIAL_W-1:0];
            end
        end
    end

    // read data is sign extended to the bus width and is zero outside the map
    always_comb
    begin
        prdata = '0;
        if (access && !pwrite)
        begin
            if (weight_hit)
            begin
                prdata = `NC_APB_DATA_W'(weight_reg[weight_index]);
            end
            else if (threshold_hit)
            begin
                prdata = `NC_APB_DATA_W'(threshold_reg);
            end
        end
    end

    // neuron n, axon a sits at index n*NUM_AXONS + a
    assign weight    = weight_reg[{weight_neuron, weight_axon}];
    assign threshold = threshold_reg;

endmodule

//--- spike_interface/spike_interface.sv
`timescale 1ns/1ps
`include "neuron_settings.svh"

module spike_interface
(
    input  logic                   router_clk,
    input  logic                   neuron_clk,
    input  logic                   rst_n,
    input  logic                   write_en,
    input  neuron_pkg::flit_t      data_in,
    input  logic                   start,
    output neuron_pkg::spike_vec_t spikes,
    output logic                   neuron_full
);

    neuron_pkg::packet_t    packet;
    neuron_pkg::axon_id_t   axon_id;
    neuron_pkg::spike_vec_t spike_reg;
    logic                   fifo_empty;
    logic                   read_req;
    logic                   write_spike;
    logic                   clear_spike_reg;

    flit_fifo i_flit_fifo
    (
        .router_clk (router_clk),
        .neuron_clk (neuron_clk),
        .rst_n      (rst_n),
        .write_en   (write_en),
        .data_in    (data_in),
        .read_req   (read_req),
        .packet     (packet),
        .empty      (fifo_empty),
        .full       (neuron_full)
    );

    // keep draining the FIFO as long as anything is stored
    assign read_req = ~fifo_empty;

    // x and y are passed through untouched, only the axon id matters here
    assign axon_id = packet[`NC_X_ADDR_W + `NC_Y_ADDR_W +: `NC_AXON_ID_W];

    // write_spike lines up with the packet, which trails the read by one clock,
    // and the registered start gives the clear one clock after the time step
    always_ff @(posedge neuron_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            write_spike     <= 1'b0;
            clear_spike_reg <= 1'b0;
        end
        else
        begin
            write_spike     <= read_req;
            clear_spike_reg <= start;
        end
    end

    // the clear wins over a set, so a packet arriving in that cycle is dropped.
    // several packets with the same axon id simply set the same bit again
    always_ff @(posedge neuron_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            spike_reg <= '0;
        end
        else if (clear_spike_reg)
        begin
            spike_reg <= '0;
        end
        else if (write_spike)
        begin
            spike_reg[axon_id] <= 1'b1;
        end
    end

    assign spikes = spike_reg;

endmodule

//--- spike_interface/flit_fifo.sv
`timescale 1ns/1ps
`include "neuron_settings.svh"

module flit_fifo
(
    input  logic                router_clk,
    input  logic                neuron_clk,
    input  logic                rst_n,
    input  logic                write_en,
    input  neuron_pkg::flit_t   data_in,
    input  logic                read_req,
    output neuron_pkg::packet_t packet,
    output logic                empty,
    output logic                full
);

    localparam int DEPTH = 1 << `NC_FIFO_ADDR_W;
    localparam int CNT_W = $clog2(`NC_FLITS_PER_PACKET);
    // one extra pointer bit tells a full FIFO from an empty one
    localparam int PTR_W = `NC_FIFO_ADDR_W + 1;

    neuron_pkg::packet_t mem [DEPTH];

    logic [CNT_W-1:0] flit_cnt;
    logic [PTR_W-1:0] wr_bin;
    logic [PTR_W-1:0] wr_bin_next;
    logic [PTR_W-1:0] wr_gray;
    logic [PTR_W-1:0] wr_gray_next;
    logic [PTR_W-1:0] rd_bin;
    logic [PTR_W-1:0] rd_bin_next;
    logic [PTR_W-1:0] rd_gray;
    logic [PTR_W-1:0] rd_gray_next;
    logic [PTR_W-1:0] rd_gray_sync1;
    logic [PTR_W-1:0] rd_gray_sync2;
    logic [PTR_W-1:0] wr_gray_sync1;
    logic [PTR_W-1:0] wr_gray_sync2;
    logic             flit_accept;
    logic             packet_done;
    logic             read_accept;

    // a flit offered while full is simply not taken
    assign flit_accept = write_en && !full;
    assign packet_done = flit_accept && (flit_cnt == CNT_W'(`NC_FLITS_PER_PACKET - 1));

    // the write pointer only moves once a whole packet has been assembled
    assign wr_bin_next  = wr_bin + PTR_W'(packet_done);
    assign wr_gray_next = wr_bin_next ^ (wr_bin_next >> 1);

    assign read_accept  = read_req && !empty;
    assign rd_bin_next  = rd_bin + PTR_W'(read_accept);
    assign rd_gray_next = rd_bin_next ^ (rd_bin_next >> 1);

    // flit k lands in nibble k of the entry under construction
    always_ff @(posedge router_clk)
    begin
        if (flit_accept)
        begin
            mem[wr_bin[`NC_FIFO_ADDR_W-1:0]][flit_cnt*`NC_FLIT_W +: `NC_FLIT_W] <= data_in;
        end
    end

    always_ff @(posedge router_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            flit_cnt      <= '0;
            wr_bin        <= '0;
            wr_gray       <= '0;
            rd_gray_sync1 <= '0;
            rd_gray_sync2 <= '0;
            full          <= 1'b0;
        end
        else
        begin
            if (flit_accept)
            begin
                flit_cnt <= packet_done ? '0 : flit_cnt + 1'b1;
            end
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_gray_next;
            // two flops bring the read pointer into the router domain
            rd_gray_sync1 <= rd_gray;
            rd_gray_sync2 <= rd_gray_sync1;
            // full is taken from the next pointer, so it rises on the very edge
            // that stores the last flit of the last free entry
            full <= (wr_gray_next == {~rd_gray_sync2[PTR_W-1:PTR_W-2],
                                      rd_gray_sync2[PTR_W-3:0]});
        end
    end

    always_ff @(posedge neuron_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_bin        <= '0;
            rd_gray       <= '0;
            wr_gray_sync1 <= '0;
            wr_gray_sync2 <= '0;
            empty         <= 1'b1;
        end
        else
        begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_gray_next;
            // completed packets become visible here two neuron clocks later
            wr_gray_sync1 <= wr_gray;
            wr_gray_sync2 <= wr_gray_sync1;
            empty <= (rd_gray_next == wr_gray_sync2);
        end
    end

    // the packet shows up one neuron clock after the read
    always_ff @(posedge neuron_clk)
    begin
        if (read_accept)
        begin
            packet <= mem[rd_bin[`NC_FIFO_ADDR_W-1:0]];
        end
    end

endmodule

//--- common/neuron_pkg.sv
`include "neuron_settings.svh"

package neuron_pkg;

    // one router flit and one reassembled packet
    typedef logic [`NC_FLIT_W-1:0] flit_t;
    typedef logic [`NC_PACKET_W-1:0] packet_t;

    // indices used to walk the weight matrix
    typedef logic [`NC_AXON_ID_W-1:0] axon_id_t;
    typedef logic [$clog2(`NC_NUM_NEURONS)-1:0] neuron_id_t;

    // one bit per axon for incoming spikes, one bit per neuron for output spikes
    typedef logic [`NC_NUM_AXONS-1:0] spike_vec_t;
    typedef logic [`NC_NUM_NEURONS-1:0] fire_vec_t;

    // weights and potentials are two's complement
    typedef logic signed [`NC_WEIGHT_W-1:0] weight_t;
    // the firing threshold shares the potential type so the compare is signed
    typedef logic signed [`NC_POTENTIAL_W-1:0] potential_t;

    // states of the serial integrate-and-fire engine
    typedef enum logic [1:0]
    {
        IDLE,
        ACCUMULATE,
        FIRE
    } update_state_e;

endpackage

//--- common/neuron_settings.svh
`ifndef NEURON_SETTINGS_SVH
`define NEURON_SETTINGS_SVH

// router flits are one nibble wide and eight of them build one packet
`define NC_FLIT_W            4
`define NC_FLITS_PER_PACKET  8
`define NC_PACKET_W          32

// destination fields fill packet bits 0 to 15, x in the low byte
`define NC_X_ADDR_W          8
`define NC_Y_ADDR_W          8

// the axon id sits directly above the y field
`define NC_AXON_ID_W         2
`define NC_NUM_AXONS         (1 << `NC_AXON_ID_W)
`define NC_NUM_NEURONS       4

// signed weight and membrane potential widths
`define NC_WEIGHT_W          8
`define NC_POTENTIAL_W       16

// four packet entries in the clock crossing FIFO
`define NC_FIFO_ADDR_W       2

// weight of neuron n, axon a lives at byte address (n*4+a)*4
`define NC_APB_ADDR_W        8
`define NC_APB_DATA_W        32
`define NC_THRESHOLD_ADDR    'h40

`endif
